// File: rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // bus field widths
    typedef logic [29:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // which master currently holds the merged bus
    typedef enum logic {
        OWNER_A = 1'b0,
        OWNER_B = 1'b1
    } arb_owner_t;

    // identification word at system-info register 0
    localparam wb_data_t SYS_ID = 32'h20191028;

    // regions keyed on word address bits 29 to 21
    localparam logic [8:0] REGION_RAM = 9'd0;
    localparam logic [8:0] REGION_SYS = 9'd1;

    // switch/LED port occupies one word
    localparam wb_addr_t SWLED_ADDR = 30'h400001;

endpackage

`default_nettype wire

// File: rtl/wb_pri_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pri_arbiter (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    // master a, data port, wins ties
    input  wire logic                  i_a_cyc,
    input  wire logic                  i_a_stb,
    input  wire logic                  i_a_we,
    input  wire soc_bus_pkg::wb_addr_t i_a_addr,
    input  wire soc_bus_pkg::wb_data_t i_a_data,
    input  wire soc_bus_pkg::wb_sel_t  i_a_sel,
    output logic                       o_a_ack,
    output logic                       o_a_stall,
    output logic                       o_a_err,
    // master b, instruction port
    input  wire logic                  i_b_cyc,
    input  wire logic                  i_b_stb,
    input  wire logic                  i_b_we,
    input  wire soc_bus_pkg::wb_addr_t i_b_addr,
    input  wire soc_bus_pkg::wb_data_t i_b_data,
    input  wire soc_bus_pkg::wb_sel_t  i_b_sel,
    output logic                       o_b_ack,
    output logic                       o_b_stall,
    output logic                       o_b_err,
    // merged bus
    output logic                       o_cyc,
    output logic                       o_stb,
    output logic                       o_we,
    output soc_bus_pkg::wb_addr_t      o_addr,
    output soc_bus_pkg::wb_data_t      o_data,
    output soc_bus_pkg::wb_sel_t       o_sel,
    input  wire logic                  i_ack,
    input  wire logic                  i_err
);

    soc_bus_pkg::arb_owner_t owner_q;
    soc_bus_pkg::arb_owner_t grant;
    logic                    owner_cyc;
    logic                    a_owns;

    assign owner_cyc = (owner_q == soc_bus_pkg::OWNER_A) ? i_a_cyc : i_b_cyc;

    // regrant only once the current owner lets go of cyc
    always_comb begin
        grant = owner_q;
        if (!owner_cyc) begin
            if (i_a_cyc) begin
                grant = soc_bus_pkg::OWNER_A;
            end else if (i_b_cyc) begin
                grant = soc_bus_pkg::OWNER_B;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= soc_bus_pkg::OWNER_A;
        end else begin
            owner_q <= grant;
        end
    end

    assign a_owns = (grant == soc_bus_pkg::OWNER_A);

    // owner request goes straight through
    assign o_cyc  = a_owns ? i_a_cyc  : i_b_cyc;
    assign o_stb  = a_owns ? i_a_stb  : i_b_stb;
    assign o_we   = a_owns ? i_a_we   : i_b_we;
    assign o_addr = a_owns ? i_a_addr : i_b_addr;
    assign o_data = a_owns ? i_a_data : i_b_data;
    assign o_sel  = a_owns ? i_a_sel  : i_b_sel;

    // losing master is held off, slaves never stall the owner
    assign o_a_stall = !a_owns && i_a_stb;
    assign o_b_stall = a_owns && i_b_stb;

    assign o_a_ack = a_owns && i_ack;
    assign o_a_err = a_owns && i_err;
    assign o_b_ack = !a_owns && i_ack;
    assign o_b_err = !a_owns && i_err;

endmodule

`default_nettype wire

// File: rtl/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_stb,
    input  wire soc_bus_pkg::wb_addr_t i_addr,
    // per-slave strobes
    output logic                       o_ram_stb,
    output logic                       o_sys_stb,
    output logic                       o_swled_stb,
    output logic                       o_err_stb,
    // slave returns
    input  wire logic                  i_ram_ack,
    input  wire logic                  i_sys_ack,
    input  wire logic                  i_swled_ack,
    input  wire soc_bus_pkg::wb_data_t i_ram_data,
    input  wire soc_bus_pkg::wb_data_t i_sys_data,
    input  wire soc_bus_pkg::wb_data_t i_swled_data,
    // back toward the arbiter
    output logic                       o_ack,
    output logic                       o_err,
    output soc_bus_pkg::wb_data_t      o_data
);

    logic ram_sel;
    logic sys_sel;
    logic swled_sel;
    logic none_sel;

    // ram and system-info take large regions, switch/led a single word
    assign ram_sel   = (i_addr[29:21] == soc_bus_pkg::REGION_RAM);
    assign sys_sel   = (i_addr[29:21] == soc_bus_pkg::REGION_SYS);
    assign swled_sel = (i_addr == soc_bus_pkg::SWLED_ADDR);
    assign none_sel  = !ram_sel && !sys_sel && !swled_sel;

    assign o_ram_stb   = i_stb && ram_sel;
    assign o_sys_stb   = i_stb && sys_sel;
    assign o_swled_stb = i_stb && swled_sel;
    assign o_err_stb   = i_stb && none_sel;

    // unmapped access answered on the next cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
            o_err <= 1'b0;
        end else begin
            o_ack <= i_ram_ack || i_sys_ack || i_swled_ack;
            o_err <= o_err_stb;
        end
    end

    // return data, zero when nobody acks
    always_ff @(posedge i_clk) begin
        if (i_ram_ack) begin
            o_data <= i_ram_data;
        end else if (i_sys_ack) begin
            o_data <= i_sys_data;
        end else if (i_swled_ack) begin
            o_data <= i_swled_data;
        end else begin
            o_data <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sys_info_dev.sv
`timescale 1ns/1ps
`default_nettype none

module sys_info_dev (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_stb,
    input  wire logic                  i_we,
    input  wire soc_bus_pkg::wb_addr_t i_addr,
    input  wire soc_bus_pkg::wb_data_t i_data,
    input  wire logic                  i_err_stb,
    output logic                       o_ack,
    output soc_bus_pkg::wb_data_t      o_data,
    output logic                       o_irq
);

    soc_bus_pkg::wb_data_t scratch_q;
    soc_bus_pkg::wb_addr_t err_addr_q;
    soc_bus_pkg::wb_data_t power_cnt_q;
    logic                  irq_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack       <= 1'b0;
            scratch_q   <= '0;
            err_addr_q  <= '0;
            power_cnt_q <= '0;
            irq_q       <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                case (i_addr[3:0])
                    4'h1: scratch_q <= i_data;
                    4'h4: irq_q     <= i_data[0];
                    default: ;
                endcase
            end
            // last word address that hit no slave
            if (i_err_stb) begin
                err_addr_q <= i_addr;
            end
            // count up, top bit sticks once reached
            if (!power_cnt_q[31]) begin
                power_cnt_q <= power_cnt_q + 32'd1;
            end else begin
                power_cnt_q[30:0] <= power_cnt_q[30:0] + 31'd1;
            end
        end
    end

    // register readback
    always_ff @(posedge i_clk) begin
        case (i_addr[3:0])
            4'h0:    o_data <= soc_bus_pkg::SYS_ID;
            4'h1:    o_data <= scratch_q;
            4'h2:    o_data <= {err_addr_q, 2'b00};
            4'h3:    o_data <= power_cnt_q;
            4'h4:    o_data <= {31'd0, irq_q};
            default: o_data <= '0;
        endcase
    end

    assign o_irq = irq_q;

endmodule

`default_nettype wire

// File: rtl/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
    parameter int RAM_AW = 10
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_stb,
    input  wire logic                  i_we,
    input  wire soc_bus_pkg::wb_addr_t i_addr,
    input  wire soc_bus_pkg::wb_data_t i_data,
    input  wire soc_bus_pkg::wb_sel_t  i_sel,
    output logic                       o_ack,
    output soc_bus_pkg::wb_data_t      o_data
);

    soc_bus_pkg::wb_data_t mem [0:(2**RAM_AW)-1];
    logic [RAM_AW-1:0]     idx;

    // upper address bits ignored, region aliases
    assign idx = i_addr[RAM_AW-1:0];

    // only lanes with sel set are written
    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (i_sel[lane]) begin
                    mem[idx][lane*8 +: 8] <= i_data[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_data <= mem[idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

endmodule

`default_nettype wire

// File: rtl/switch_led_dev.sv
`timescale 1ns/1ps
`default_nettype none

module switch_led_dev (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_stb,
    input  wire logic                  i_we,
    input  wire soc_bus_pkg::wb_data_t i_data,
    input  wire soc_bus_pkg::wb_sel_t  i_sel,
    input  wire logic [15:0]           i_switches,
    output logic                       o_ack,
    output soc_bus_pkg::wb_data_t      o_data,
    output logic [15:0]                o_leds
);

    logic [15:0] leds_q;

    // led register sits in the two low byte lanes
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            leds_q <= '0;
            o_ack  <= 1'b0;
        end else begin
            o_ack <= i_stb;
            if (i_stb && i_we) begin
                if (i_sel[0]) begin
                    leds_q[7:0] <= i_data[7:0];
                end
                if (i_sel[1]) begin
                    leds_q[15:8] <= i_data[15:8];
                end
            end
        end
    end

    // switches high, leds low
    always_ff @(posedge i_clk) begin
        o_data <= {i_switches, leds_q};
    end

    assign o_leds = leds_q;

endmodule

`default_nettype wire

// File: rtl/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
    parameter int RAM_AW = 10
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    // master a, data port
    input  wire logic                  i_a_cyc,
    input  wire logic                  i_a_stb,
    input  wire logic                  i_a_we,
    input  wire soc_bus_pkg::wb_addr_t i_a_addr,
    input  wire soc_bus_pkg::wb_data_t i_a_data,
    input  wire soc_bus_pkg::wb_sel_t  i_a_sel,
    output logic                       o_a_ack,
    output logic                       o_a_stall,
    output logic                       o_a_err,
    output soc_bus_pkg::wb_data_t      o_a_data,
    // master b, instruction port
    input  wire logic                  i_b_cyc,
    input  wire logic                  i_b_stb,
    input  wire logic                  i_b_we,
    input  wire soc_bus_pkg::wb_addr_t i_b_addr,
    input  wire soc_bus_pkg::wb_data_t i_b_data,
    input  wire soc_bus_pkg::wb_sel_t  i_b_sel,
    output logic                       o_b_ack,
    output logic                       o_b_stall,
    output logic                       o_b_err,
    output soc_bus_pkg::wb_data_t      o_b_data,
    // board io
    input  wire logic [15:0]           i_switches,
    output logic [15:0]                o_leds,
    output logic                       o_irq
);

    // merged bus after arbitration
    logic                  bus_cyc;
    logic                  bus_stb;
    logic                  bus_we;
    soc_bus_pkg::wb_addr_t bus_addr;
    soc_bus_pkg::wb_data_t bus_wdata;
    soc_bus_pkg::wb_sel_t  bus_sel;
    logic                  bus_ack;
    logic                  bus_err;
    soc_bus_pkg::wb_data_t bus_rdata;

    // slave strobes and returns
    logic                  ram_stb;
    logic                  sys_stb;
    logic                  swled_stb;
    logic                  err_stb;
    logic                  ram_ack;
    logic                  sys_ack;
    logic                  swled_ack;
    soc_bus_pkg::wb_data_t ram_rdata;
    soc_bus_pkg::wb_data_t sys_rdata;
    soc_bus_pkg::wb_data_t swled_rdata;

    wb_pri_arbiter arb_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_addr  (i_a_addr),
        .i_a_data  (i_a_data),
        .i_a_sel   (i_a_sel),
        .o_a_ack   (o_a_ack),
        .o_a_stall (o_a_stall),
        .o_a_err   (o_a_err),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_addr  (i_b_addr),
        .i_b_data  (i_b_data),
        .i_b_sel   (i_b_sel),
        .o_b_ack   (o_b_ack),
        .o_b_stall (o_b_stall),
        .o_b_err   (o_b_err),
        .o_cyc     (bus_cyc),
        .o_stb     (bus_stb),
        .o_we      (bus_we),
        .o_addr    (bus_addr),
        .o_data    (bus_wdata),
        .o_sel     (bus_sel),
        .i_ack     (bus_ack),
        .i_err     (bus_err)
    );

    // stb only counts inside a cycle
    bus_decoder dec_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_stb        (bus_cyc && bus_stb),
        .i_addr       (bus_addr),
        .o_ram_stb    (ram_stb),
        .o_sys_stb    (sys_stb),
        .o_swled_stb  (swled_stb),
        .o_err_stb    (err_stb),
        .i_ram_ack    (ram_ack),
        .i_sys_ack    (sys_ack),
        .i_swled_ack  (swled_ack),
        .i_ram_data   (ram_rdata),
        .i_sys_data   (sys_rdata),
        .i_swled_data (swled_rdata),
        .o_ack        (bus_ack),
        .o_err        (bus_err),
        .o_data       (bus_rdata)
    );

    sys_info_dev sys_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stb     (sys_stb),
        .i_we      (bus_we),
        .i_addr    (bus_addr),
        .i_data    (bus_wdata),
        .i_err_stb (err_stb),
        .o_ack     (sys_ack),
        .o_data    (sys_rdata),
        .o_irq     (o_irq)
    );

    scratch_ram #(
        .RAM_AW (RAM_AW)
    ) ram_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stb   (ram_stb),
        .i_we    (bus_we),
        .i_addr  (bus_addr),
        .i_data  (bus_wdata),
        .i_sel   (bus_sel),
        .o_ack   (ram_ack),
        .o_data  (ram_rdata)
    );

    switch_led_dev swled_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (swled_stb),
        .i_we       (bus_we),
        .i_data     (bus_wdata),
        .i_sel      (bus_sel),
        .i_switches (i_switches),
        .o_ack      (swled_ack),
        .o_data     (swled_rdata),
        .o_leds     (o_leds)
    );

    // both masters see read data, ack tells whose it is
    assign o_a_data = bus_rdata;
    assign o_b_data = bus_rdata;

endmodule

`default_nettype wire

// File: sim/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    // about 30 transfers of a few cycles each plus reset, with a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam soc_bus_pkg::wb_addr_t SYS_BASE = {soc_bus_pkg::REGION_SYS, 21'd0};
    localparam soc_bus_pkg::wb_addr_t BAD_ADDR = 30'h3000000;

    logic                  clk;
    logic                  rst_n;
    logic                  a_cyc;
    logic                  a_stb;
    logic                  a_we;
    soc_bus_pkg::wb_addr_t a_addr;
    soc_bus_pkg::wb_data_t a_wdata;
    soc_bus_pkg::wb_sel_t  a_sel;
    logic                  a_ack;
    logic                  a_stall;
    logic                  a_err;
    soc_bus_pkg::wb_data_t a_rdata;
    logic                  b_cyc;
    logic                  b_stb;
    logic                  b_we;
    soc_bus_pkg::wb_addr_t b_addr;
    soc_bus_pkg::wb_data_t b_wdata;
    soc_bus_pkg::wb_sel_t  b_sel;
    logic                  b_ack;
    logic                  b_stall;
    logic                  b_err;
    soc_bus_pkg::wb_data_t b_rdata;
    logic [15:0]           switches;
    logic [15:0]           leds;
    logic                  irq;

    int    value_errors;
    int    proto_errors;
    int    stray_count;
    int    cycle_count;
    string cur_test;

    soc_bus_top #(
        .RAM_AW (10)
    ) dut_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_a_cyc    (a_cyc),
        .i_a_stb    (a_stb),
        .i_a_we     (a_we),
        .i_a_addr   (a_addr),
        .i_a_data   (a_wdata),
        .i_a_sel    (a_sel),
        .o_a_ack    (a_ack),
        .o_a_stall  (a_stall),
        .o_a_err    (a_err),
        .o_a_data   (a_rdata),
        .i_b_cyc    (b_cyc),
        .i_b_stb    (b_stb),
        .i_b_we     (b_we),
        .i_b_addr   (b_addr),
        .i_b_data   (b_wdata),
        .i_b_sel    (b_sel),
        .o_b_ack    (b_ack),
        .o_b_stall  (b_stall),
        .o_b_err    (b_err),
        .o_b_data   (b_rdata),
        .i_switches (switches),
        .o_leds     (leds),
        .o_irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // a response must never arrive on a port with no open cycle
    always @(negedge clk) begin
        if (rst_n && (a_ack || a_err) && !a_cyc) begin
            $display("response reached master A while its cycle was closed");
            stray_count = stray_count + 1;
        end
        if (rst_n && (b_ack || b_err) && !b_cyc) begin
            $display("response reached master B while its cycle was closed");
            stray_count = stray_count + 1;
        end
    end

    task automatic report_mismatch(
        input string                 what,
        input soc_bus_pkg::wb_data_t expected,
        input soc_bus_pkg::wb_data_t actual
    );
        $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, expected, actual);
        value_errors++;
    endtask

    task automatic set_port(
        input logic                  use_b,
        input logic                  cyc,
        input logic                  stb,
        input logic                  we,
        input soc_bus_pkg::wb_addr_t addr,
        input soc_bus_pkg::wb_data_t data,
        input soc_bus_pkg::wb_sel_t  sel
    );
        if (use_b) begin
            b_cyc   = cyc;
            b_stb   = stb;
            b_we    = we;
            b_addr  = addr;
            b_wdata = data;
            b_sel   = sel;
        end else begin
            a_cyc   = cyc;
            a_stb   = stb;
            a_we    = we;
            a_addr  = addr;
            a_wdata = data;
            a_sel   = sel;
        end
    endtask

    // one pipelined transfer, called and returning just after a rising edge
    task automatic do_transfer(
        input  logic                  use_b,
        input  logic                  we,
        input  soc_bus_pkg::wb_addr_t addr,
        input  soc_bus_pkg::wb_data_t wdata,
        input  soc_bus_pkg::wb_sel_t  sel,
        output soc_bus_pkg::wb_data_t rdata,
        output logic                  got_err,
        output int                    stalls
    );
        logic accepted;
        logic ack_seen;
        logic err_seen;
        int   wait_cycles;
        stalls = 0;
        wait_cycles = 0;
        accepted = 1'b0;
        ack_seen = 1'b0;
        err_seen = 1'b0;
        rdata = '0;
        set_port(use_b, 1'b1, 1'b1, we, addr, wdata, sel);
        while (!accepted) begin
            @(negedge clk);
            accepted = use_b ? !b_stall : !a_stall;
            if (!accepted) begin
                stalls++;
            end
            @(posedge clk);
            #1;
        end
        set_port(use_b, 1'b1, 1'b0, we, addr, wdata, sel);
        while (!ack_seen && !err_seen) begin
            @(negedge clk);
            wait_cycles++;
            ack_seen = use_b ? b_ack : a_ack;
            err_seen = use_b ? b_err : a_err;
            rdata = use_b ? b_rdata : a_rdata;
        end
        if (ack_seen && err_seen) begin
            $display("%s: ack and err returned together for one transfer", cur_test);
            proto_errors++;
        end
        if (ack_seen && wait_cycles != 2) begin
            report_mismatch("ack latency", 32'd2, wait_cycles);
        end
        if (err_seen && wait_cycles != 1) begin
            report_mismatch("err latency", 32'd1, wait_cycles);
        end
        got_err = err_seen;
        @(posedge clk);
        #1;
        set_port(use_b, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic write_checked(
        input logic                  use_b,
        input soc_bus_pkg::wb_addr_t addr,
        input soc_bus_pkg::wb_data_t data,
        input soc_bus_pkg::wb_sel_t  sel
    );
        soc_bus_pkg::wb_data_t unused_rd;
        logic                  got_err;
        int                    stalls;
        do_transfer(use_b, 1'b1, addr, data, sel, unused_rd, got_err, stalls);
        if (got_err) begin
            $display("%s: write to %h was answered with err", cur_test, addr);
            proto_errors++;
        end
    endtask

    task automatic wb_write_a(
        input soc_bus_pkg::wb_addr_t addr,
        input soc_bus_pkg::wb_data_t data,
        input soc_bus_pkg::wb_sel_t  sel
    );
        write_checked(1'b0, addr, data, sel);
    endtask

    task automatic wb_write_b(
        input soc_bus_pkg::wb_addr_t addr,
        input soc_bus_pkg::wb_data_t data,
        input soc_bus_pkg::wb_sel_t  sel
    );
        write_checked(1'b1, addr, data, sel);
    endtask

    task automatic wb_read_a(
        input  soc_bus_pkg::wb_addr_t addr,
        output soc_bus_pkg::wb_data_t rdata,
        output logic                  got_err
    );
        int stalls;
        do_transfer(1'b0, 1'b0, addr, '0, 4'hf, rdata, got_err, stalls);
    endtask

    task automatic wb_read_b(
        input  soc_bus_pkg::wb_addr_t addr,
        output soc_bus_pkg::wb_data_t rdata,
        output logic                  got_err,
        output int                    stalls
    );
        do_transfer(1'b1, 1'b0, addr, '0, 4'hf, rdata, got_err, stalls);
    endtask

    task automatic test_ram();
        soc_bus_pkg::wb_addr_t addrs [4];
        soc_bus_pkg::wb_data_t model [4];
        soc_bus_pkg::wb_data_t lane_data;
        soc_bus_pkg::wb_data_t rd;
        logic                  got_err;
        int                    i;
        cur_test = "test_ram";
        addrs[0] = 30'h000010;
        addrs[1] = 30'h000011;
        addrs[2] = 30'h0002a5;
        addrs[3] = 30'h0003ff;
        for (i = 0; i < 4; i++) begin
            model[i] = $urandom();
            wb_write_a(addrs[i], model[i], 4'hf);
        end
        // only byte lane 1 changes
        lane_data = $urandom();
        wb_write_a(addrs[2], lane_data, 4'b0010);
        model[2][15:8] = lane_data[15:8];
        for (i = 0; i < 4; i++) begin
            wb_read_a(addrs[i], rd, got_err);
            if (got_err) begin
                $display("%s: read of RAM word %h returned err", cur_test, addrs[i]);
                proto_errors++;
            end
            if (rd !== model[i]) begin
                report_mismatch("ram word", model[i], rd);
            end
        end
    endtask

    task automatic test_sys_info();
        soc_bus_pkg::wb_data_t rd;
        soc_bus_pkg::wb_data_t wdata;
        soc_bus_pkg::wb_data_t first_cnt;
        logic                  got_err;
        cur_test = "test_sys_info";
        wb_read_a(SYS_BASE, rd, got_err);
        if (rd !== soc_bus_pkg::SYS_ID) begin
            report_mismatch("id register", soc_bus_pkg::SYS_ID, rd);
        end
        wdata = $urandom();
        wb_write_a(SYS_BASE + 30'd1, wdata, 4'hf);
        wb_read_a(SYS_BASE + 30'd1, rd, got_err);
        if (rd !== wdata) begin
            report_mismatch("scratch", wdata, rd);
        end
        // interrupt flag set then cleared
        wb_write_a(SYS_BASE + 30'd4, 32'h1, 4'hf);
        if (irq !== 1'b1) begin
            report_mismatch("o_irq after set", 32'h1, {31'd0, irq});
        end
        wb_read_a(SYS_BASE + 30'd4, rd, got_err);
        if (rd !== 32'h1) begin
            report_mismatch("irq flag", 32'h1, rd);
        end
        wb_write_a(SYS_BASE + 30'd4, 32'h0, 4'hf);
        if (irq !== 1'b0) begin
            report_mismatch("o_irq after clear", 32'h0, {31'd0, irq});
        end
        wb_read_a(SYS_BASE + 30'd4, rd, got_err);
        if (rd !== 32'h0) begin
            report_mismatch("irq flag", 32'h0, rd);
        end
        wb_read_a(SYS_BASE + 30'd3, first_cnt, got_err);
        wb_read_a(SYS_BASE + 30'd3, rd, got_err);
        if (!(rd > first_cnt)) begin
            $display("[ERROR] %s: power counter expected above %h actual %h",
                     cur_test, first_cnt, rd);
            value_errors++;
        end
    endtask

    task automatic test_bus_error();
        soc_bus_pkg::wb_data_t rd;
        logic                  got_err;
        cur_test = "test_bus_error";
        wb_read_a(BAD_ADDR, rd, got_err);
        if (!got_err) begin
            $display("%s: unmapped address %h was acknowledged instead of err",
                     cur_test, BAD_ADDR);
            proto_errors++;
        end
        // byte address of the failed access
        wb_read_a(SYS_BASE + 30'd2, rd, got_err);
        if (rd !== {BAD_ADDR, 2'b00}) begin
            report_mismatch("error address", {BAD_ADDR, 2'b00}, rd);
        end
    endtask

    task automatic test_switch_led();
        soc_bus_pkg::wb_data_t sw_val;
        soc_bus_pkg::wb_data_t wdata;
        soc_bus_pkg::wb_data_t rd;
        logic                  got_err;
        cur_test = "test_switch_led";
        sw_val = $urandom();
        switches = sw_val[15:0];
        wdata = $urandom();
        wb_write_a(soc_bus_pkg::SWLED_ADDR, wdata, 4'hf);
        if (leds !== wdata[15:0]) begin
            report_mismatch("o_leds", {16'd0, wdata[15:0]}, {16'd0, leds});
        end
        wb_read_a(soc_bus_pkg::SWLED_ADDR, rd, got_err);
        if (rd !== {sw_val[15:0], wdata[15:0]}) begin
            report_mismatch("switch/led read", {sw_val[15:0], wdata[15:0]}, rd);
        end
    endtask

    task automatic test_arbitration();
        soc_bus_pkg::wb_data_t word_a;
        soc_bus_pkg::wb_data_t word_b;
        soc_bus_pkg::wb_data_t rd_a;
        soc_bus_pkg::wb_data_t rd_b;
        logic                  err_a;
        logic                  err_b;
        logic                  a_done;
        int                    b_stalls;
        cur_test = "test_arbitration";
        word_a = $urandom();
        word_b = $urandom();
        // a writes last so it owns the bus when both request
        wb_write_b(30'h000041, word_b, 4'hf);
        wb_write_a(30'h000040, word_a, 4'hf);
        a_done = 1'b0;
        fork
            begin
                wb_read_a(30'h000040, rd_a, err_a);
                a_done = 1'b1;
            end
            wb_read_b(30'h000041, rd_b, err_b, b_stalls);
            while (!a_done) begin
                @(negedge clk);
                if (a_cyc && b_stb && !b_stall) begin
                    $display("%s: master B was not stalled while A held the bus", cur_test);
                    proto_errors++;
                end
                if (a_cyc && (b_ack || b_err)) begin
                    $display("%s: master B got a response while A owned the bus", cur_test);
                    proto_errors++;
                end
            end
        join
        if (b_stalls == 0) begin
            $display("%s: master B was never stalled", cur_test);
            proto_errors++;
        end
        if (err_a || err_b) begin
            $display("%s: a RAM read returned err", cur_test);
            proto_errors++;
        end
        if (rd_a !== word_a) begin
            report_mismatch("master A word", word_a, rd_a);
        end
        if (rd_b !== word_b) begin
            report_mismatch("master B word", word_b, rd_b);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        switches = '0;
        value_errors = 0;
        proto_errors = 0;
        stray_count = 0;
        cycle_count = 0;
        cur_test = "reset";
        set_port(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        set_port(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
        void'($urandom(32'h36a4));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_ram();
        test_sys_info();
        test_bus_error();
        test_switch_led();
        test_arbitration();
        repeat (2) @(posedge clk);
        $display("run complete: %0d value errors, %0d protocol errors",
                 value_errors, proto_errors + stray_count);
        if (value_errors == 0 && proto_errors == 0 && stray_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/soc_bus_pkg.sv
rtl/wb_pri_arbiter.sv
rtl/bus_decoder.sv
rtl/sys_info_dev.sv
rtl/scratch_ram.sv
rtl/switch_led_dev.sv
rtl/soc_bus_top.sv
sim/tb_soc_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_soc_bus -f verilog.f \
    && ./obj_dir/Vtb_soc_bus | tee sim.log

# the run passes only when the log holds the pass line
grep -q "^TEST PASS$" sim.log && echo "simulation passed, log in sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }
